// File: project.f
md_core_pkg.sv
core_settings_regs.sv
cart_header_sniffer.sv
pad_remap.sv
backup_ram_sequencer.sv
video_formatter.sv
md_core_top.sv
tb_md_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_md_core
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tb_md_core.sv
////////////////////////////////////////////////////////////////////////////
// console core glue testbench
// directed tests for settings, header sniffer, pads, backup ram and video,
// with a storage model that answers the backup ram requests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_md_core;

	import md_core_pkg::*;

	localparam int TRANSFER_LIMIT = 128 * 4 + 16;  // 4 cycles per sector plus slack
	// five backup transfers, the short tests and margin
	localparam int TIMEOUT_CYCLES = 5000;

	localparam logic [31:0] REG_ADDRS [5] = '{32'h00, 32'h04, 32'h08, 32'h10, 32'h14};
	localparam logic [7:0]  LEVELS [16] = '{
		8'd0,   8'd27,  8'd49,  8'd71,  8'd87,  8'd103, 8'd119, 8'd130,
		8'd146, 8'd157, 8'd174, 8'd190, 8'd206, 8'd228, 8'd255, 8'd255
	};

	logic                  clk_sys;
	logic                  rst_n;
	logic [ADDR_W-1:0]     bridge_addr;
	logic                  bridge_wr;
	logic [DATA_W-1:0]     bridge_wr_data;
	logic                  rom_loading;
	logic                  rom_wr;
	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [ROM_DATA_W-1:0] rom_data;
	host_keys_t            host_keys [PAD_COUNT];
	logic                  in_menu;
	logic                  bk_change;
	logic                  sd_ack;
	logic [3:0]            r;
	logic [3:0]            g;
	logic [3:0]            b;
	logic                  hs;
	logic                  vs;
	logic                  hblank;
	logic                  vblank;
	vid_mode_e             resolution;
	logic                  interlaced;
	core_cfg_t             cfg;
	cart_quirks_t          quirks;
	gun_cfg_t              gun;
	logic [ROM_ADDR_W-1:0] rom_size;
	md_pad_t               pads [PAD_COUNT];
	logic                  sd_rd;
	logic                  sd_wr;
	logic [BK_LBA_W-1:0]   sd_lba;
	logic                  bk_busy;
	video_word_u           video_rgb;
	logic                  video_de;
	logic                  video_hs;
	logic                  video_vs;

	int checks = 0;
	int errors = 0;
	int cycles = 0;

	md_core_top md_core_top_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.bridge_addr    (bridge_addr),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.rom_loading    (rom_loading),
		.rom_wr         (rom_wr),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.host_keys      (host_keys),
		.in_menu        (in_menu),
		.bk_change      (bk_change),
		.sd_ack         (sd_ack),
		.r              (r),
		.g              (g),
		.b              (b),
		.hs             (hs),
		.vs             (vs),
		.hblank         (hblank),
		.vblank         (vblank),
		.resolution     (resolution),
		.interlaced     (interlaced),
		.cfg            (cfg),
		.quirks         (quirks),
		.gun            (gun),
		.rom_size       (rom_size),
		.pads           (pads),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_lba         (sd_lba),
		.bk_busy        (bk_busy),
		.video_rgb      (video_rgb),
		.video_de       (video_de),
		.video_hs       (video_hs),
		.video_vs       (video_vs)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// storage model acks 2 cycles after a request and holds it for one
	always begin
		@(posedge clk_sys);
		#1;
		if (sd_rd || sd_wr) begin
			repeat (2) @(posedge clk_sys);
			#1 sd_ack = 1'b1;
			@(posedge clk_sys);
			#1 sd_ack = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string failure);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("Error at %0t ns: %s", $time, failure);
		end
	endtask

	// Z Y X mode start B C A up down left right
	function automatic logic [11:0] remap_keys(input logic [15:0] k);
		return {k[9], k[6], k[8], k[14], k[15], k[4], k[5], k[7], k[0], k[1], k[2], k[3]};
	endfunction

	function automatic logic [10:0] mode_index(input int res, input logic il);
		case (res)
			0:       return 11'd0;
			1:       return il ? 11'd4 : 11'd1;
			2:       return 11'd2;
			default: return 11'd3;
		endcase
	endfunction

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
		bridge_addr    = addr;
		bridge_wr_data = data;
		bridge_wr      = 1'b1;
		tick();
		bridge_wr = 1'b0;
	endtask

	task automatic write_rom(input logic [24:0] addr, input logic [15:0] data);
		rom_addr = addr;
		rom_data = data;
		rom_wr   = 1'b1;
		tick();
		rom_wr = 1'b0;
	endtask

	task automatic begin_download();
		rom_loading = 1'b1;
		tick();
	endtask

	// header words are byte swapped with the first char in the high byte of 0x182
	task automatic write_header(input logic [63:0] code);
		write_rom(25'h182, {code[63:56], 8'h20});
		write_rom(25'h184, {code[47:40], code[55:48]});
		write_rom(25'h186, {code[31:24], code[39:32]});
		write_rom(25'h188, {code[15:8], code[23:16]});
		write_rom(25'h18A, {8'h20, code[7:0]});
		write_rom(25'h18C, 16'h0000);
	endtask

	task automatic end_download(input logic [24:0] last_addr);
		write_rom(last_addr, 16'($urandom));
		rom_loading = 1'b0;
	endtask

	task automatic check_transfer(input logic is_load, input string what);
		int   pulses;
		int   waited;
		logic strobe;
		logic strobe_q;
		pulses   = 0;
		waited   = 0;
		strobe_q = 1'b0;
		tick();
		expect_true(bk_busy, {what, ": transfer did not start"});
		while (bk_busy && waited < TRANSFER_LIMIT) begin
			strobe = is_load ? sd_rd : sd_wr;
			expect_true(!(is_load ? sd_wr : sd_rd), {what, ": strobe for the wrong direction"});
			if (strobe && !strobe_q) begin
				check_value({what, " sector lba"}, sd_lba, pulses);
				pulses++;
			end
			strobe_q = strobe;
			waited++;
			tick();
		end
		expect_true(!bk_busy, {what, ": bk_busy stayed high"});
		check_value({what, " sector count"}, pulses, BK_SECTORS);
		check_value({what, " last lba"}, sd_lba, 127);
	endtask

	task automatic expect_idle(input int n, input string failure);
		repeat (n) begin
			tick();
			expect_true(!bk_busy && !sd_rd && !sd_wr, failure);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_settings();
		logic [4:0] exp;
		exp = 5'b00111;               // border cram_dots spr_limit hifi_pcm fm_en
		check_value("settings after reset", cfg, exp);
		for (int i = 0; i < 5; i++) begin
			repeat (2) begin
				exp[4-i] = ~exp[4-i];
				bridge_write(REG_ADDRS[i], {31'($urandom), exp[4-i]});
				check_value("settings after write", cfg, exp);
			end
		end
		bridge_write(32'h0C, 32'hFFFF_FFFF);  // unmapped
		check_value("settings after unmapped write", cfg, exp);
	endtask

	task automatic test_cart_header();
		cart_quirks_t exp_q;
		begin_download();
		check_value("quirks at first download", quirks, 0);
		write_header("MK-1215 ");
		exp_q        = '0;
		exp_q.eeprom = 1'b1;
		check_value("quirks for MK-1215", quirks, exp_q);
		check_value("gun for MK-1215", gun, {1'b0, 8'd44});
		end_download(25'h0F_FFFE);
		check_transfer(1'b1, "load after MK-1215");
		check_value("rom size", rom_size, 25'h0F_FFFE);

		begin_download();
		check_value("quirks cleared at download start", quirks, 0);
		write_header("T-95096-");
		check_value("quirks for T-95096-", quirks, 0);
		check_value("gun for T-95096-", gun, {1'b1, 8'd52});
		end_download(25'h3F_FFFE);
		check_transfer(1'b1, "load after T-95096-");
		check_value("rom size", rom_size, 25'h3F_FFFE);

		// unknown code keeps the quirks and only the gun drops back
		begin_download();
		write_header("MK-1215 ");
		write_header("MK-1533 ");
		check_value("gun for MK-1533", gun, {1'b0, 8'd100});
		write_header("XY-12345");
		check_value("quirks after unknown code", quirks, exp_q);
		check_value("gun after unknown code", gun, {1'b0, 8'd44});
		end_download(25'h01_FFFE);
		check_transfer(1'b1, "load after unknown code");
		check_value("rom size", rom_size, 25'h01_FFFE);
	endtask

	task automatic test_pads();
		logic [15:0] keys [PAD_COUNT];
		logic [15:0] prev [PAD_COUNT];
		for (int p = 0; p < PAD_COUNT; p++)
			prev[p] = host_keys[p];
		repeat (8) begin
			for (int p = 0; p < PAD_COUNT; p++) begin
				keys[p]      = 16'($urandom);
				host_keys[p] = keys[p];
			end
			tick();
			for (int p = 0; p < PAD_COUNT; p++)
				check_value("pad after one edge", pads[p], remap_keys(prev[p]));
			tick();
			for (int p = 0; p < PAD_COUNT; p++) begin
				check_value("pad after two edges", pads[p], remap_keys(keys[p]));
				prev[p] = keys[p];
			end
		end
	endtask

	task automatic test_backup_ram();
		in_menu   = 1'b0;
		bk_change = 1'b1;
		tick();
		bk_change = 1'b0;
		in_menu   = 1'b1;             // pending save goes out now
		check_transfer(1'b0, "save");
		in_menu = 1'b0;
		tick();

		begin_download();
		write_header("MK-1229 ");
		expect_true(quirks.svp, "svp quirk not set for MK-1229");
		end_download(25'h07_FFFE);
		expect_idle(16, "load started with the svp quirk set");
		bk_change = 1'b1;
		tick();
		in_menu = 1'b1;
		expect_idle(16, "save started with the svp quirk set");
		in_menu   = 1'b0;
		bk_change = 1'b0;
		tick();

		begin_download();
		expect_true(!quirks.svp, "svp quirk not cleared at download start");
		write_header("T-89016 ");
		expect_true(quirks.fifo, "fifo quirk not set for T-89016");
		end_download(25'h07_FFFE);
		check_transfer(1'b1, "load after svp cart");
		in_menu = 1'b1;               // a pending save would go out now
		expect_idle(8, "save started after the load cleared it");
		in_menu = 1'b0;
	endtask

	task automatic test_video();
		logic [3:0] cr;
		logic [3:0] cg;
		logic [3:0] cb;
		hblank = 1'b0;
		vblank = 1'b0;
		repeat (8) begin
			cr = 4'($urandom);
			cg = 4'($urandom);
			cb = 4'($urandom);
			r  = cr;
			g  = cg;
			b  = cb;
			tick();
			check_value("video_de active", video_de, 1);
			check_value("active rgb", video_rgb, {LEVELS[cr], LEVELS[cg], LEVELS[cb]});
		end
		hblank = 1'b1;
		for (int res = 0; res < 4; res++) begin
			for (int il = 0; il < 2; il++) begin
				resolution = vid_mode_e'(res);
				interlaced = il[0];
				tick();
				check_value("video_de blanked", video_de, 0);
				check_value("mode word", video_rgb, {mode_index(res, il[0]), 13'd0});
			end
		end
		hblank = 1'b0;
		vblank = 1'b1;
		resolution = vid_mode_e'(2);
		interlaced = 1'b0;
		tick();
		check_value("mode word in vblank", video_rgb, {11'd2, 13'd0});
		vblank = 1'b0;
	endtask

	task automatic test_sync();
		hs = 1'b1;
		tick();
		check_value("video_hs on rising hs", video_hs, 1);
		check_value("video_vs during hs", video_vs, 0);
		repeat (3) begin
			tick();
			check_value("video_hs with hs held", video_hs, 0);
		end
		hs = 1'b0;
		tick();
		vs = 1'b1;
		tick();
		check_value("video_vs on rising vs", video_vs, 1);
		check_value("video_hs during vs", video_hs, 0);
		repeat (3) begin
			tick();
			check_value("video_vs with vs held", video_vs, 0);
		end
		vs = 1'b0;
		tick();
	endtask

	initial begin
		void'($urandom(32'h17d5_b3d4));
		clk_sys        = 1'b0;
		rst_n          = 1'b0;
		bridge_addr    = '0;
		bridge_wr      = 1'b0;
		bridge_wr_data = '0;
		rom_loading    = 1'b0;
		rom_wr         = 1'b0;
		rom_addr       = '0;
		rom_data       = '0;
		host_keys      = '{default: '0};
		in_menu        = 1'b0;
		bk_change      = 1'b0;
		sd_ack         = 1'b0;
		r              = '0;
		g              = '0;
		b              = '0;
		hs             = 1'b0;
		vs             = 1'b0;
		hblank         = 1'b0;
		vblank         = 1'b0;
		resolution     = RES_256_224;
		interlaced     = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		tick();

		test_settings();
		test_cart_header();
		test_pads();
		test_backup_ram();
		test_video();
		test_sync();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: md_core_top.sv
////////////////////////////////////////////////////////////////////////////
// console core glue top level
// settings, header sniffer, pad remap, backup ram and video output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module md_core_top (
	input  logic                               clk_sys,
	input  logic                               rst_n,
	// host bridge
	input  logic [md_core_pkg::ADDR_W-1:0]     bridge_addr,
	input  logic                               bridge_wr,
	input  logic [md_core_pkg::DATA_W-1:0]     bridge_wr_data,
	// rom download
	input  logic                               rom_loading,
	input  logic                               rom_wr,
	input  logic [md_core_pkg::ROM_ADDR_W-1:0] rom_addr,
	input  logic [md_core_pkg::ROM_DATA_W-1:0] rom_data,
	// controllers and menu
	input  md_core_pkg::host_keys_t            host_keys [md_core_pkg::PAD_COUNT],
	input  logic                               in_menu,
	// backup ram storage
	input  logic                               bk_change,
	input  logic                               sd_ack,
	// console pixel stream
	input  logic [3:0]                         r,
	input  logic [3:0]                         g,
	input  logic [3:0]                         b,
	input  logic                               hs,
	input  logic                               vs,
	input  logic                               hblank,
	input  logic                               vblank,
	input  md_core_pkg::vid_mode_e             resolution,
	input  logic                               interlaced,
	output md_core_pkg::core_cfg_t             cfg,
	output md_core_pkg::cart_quirks_t          quirks,
	output md_core_pkg::gun_cfg_t              gun,
	output logic [md_core_pkg::ROM_ADDR_W-1:0] rom_size,
	output md_core_pkg::md_pad_t               pads [md_core_pkg::PAD_COUNT],
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic [md_core_pkg::BK_LBA_W-1:0]   sd_lba,
	output logic                               bk_busy,
	output md_core_pkg::video_word_u           video_rgb,
	output logic                               video_de,
	output logic                               video_hs,
	output logic                               video_vs
);

	core_settings_regs settings_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.bridge_addr    (bridge_addr),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.cfg            (cfg)
	);

	cart_header_sniffer sniffer_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.rom_loading (rom_loading),
		.rom_wr      (rom_wr),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.quirks      (quirks),
		.gun         (gun),
		.rom_size    (rom_size)
	);

	pad_remap pad_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.host_keys (host_keys),
		.pads      (pads)
	);

	backup_ram_sequencer bk_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.svp_quirk   (quirks.svp),
		.rom_loading (rom_loading),
		.in_menu     (in_menu),
		.bk_change   (bk_change),
		.sd_ack      (sd_ack),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_lba      (sd_lba),
		.bk_busy     (bk_busy)
	);

	video_formatter video_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.r          (r),
		.g          (g),
		.b          (b),
		.hs         (hs),
		.vs         (vs),
		.hblank     (hblank),
		.vblank     (vblank),
		.resolution (resolution),
		.interlaced (interlaced),
		.video_rgb  (video_rgb),
		.video_de   (video_de),
		.video_hs   (video_hs),
		.video_vs   (video_vs)
	);

endmodule

// File: video_formatter.sv
////////////////////////////////////////////////////////////////////////////
// video output formatter
// 4-bit colour through the level table, data enable, sync edge pulses,
// and the video mode word on the rgb bus while blanked
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module video_formatter (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic [3:0]              r,
	input  logic [3:0]              g,
	input  logic [3:0]              b,
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    hblank,
	input  logic                    vblank,
	input  md_core_pkg::vid_mode_e  resolution,
	input  logic                    interlaced,
	output md_core_pkg::video_word_u video_rgb,
	output logic                    video_de,
	output logic                    video_hs,
	output logic                    video_vs
);

	import md_core_pkg::*;

	logic        active;
	logic [10:0] mode_idx;
	logic        hs_q;
	logic        vs_q;
	video_word_u rgb_next;

	assign active = ~(hblank | vblank);

	// scaler mode slot per resolution
	always_comb begin
		case (resolution)
			RES_256_224: mode_idx = 11'd0;
			RES_320_224: mode_idx = interlaced ? 11'd4 : 11'd1;  // 448i uses its own slot
			RES_256_240: mode_idx = 11'd2;
			default:     mode_idx = 11'd3;
		endcase
	end

	always_comb begin
		if (active) begin
			rgb_next.color.red   = COLOR_LUT[r];
			rgb_next.color.green = COLOR_LUT[g];
			rgb_next.color.blue  = COLOR_LUT[b];
		end else begin
			rgb_next.mode.index = mode_idx;
			rgb_next.mode.zero  = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		video_rgb <= rgb_next;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			video_de <= 1'b0;
			video_hs <= 1'b0;
			video_vs <= 1'b0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
		end else begin
			video_de <= active;
			video_hs <= hs & ~hs_q;   // rising edge only
			video_vs <= vs & ~vs_q;
			hs_q     <= hs;
			vs_q     <= vs;
		end
	end

endmodule

// File: backup_ram_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// backup ram sequencer
// auto-save pending flag, and sector by sector load or save of the
// backup ram with a request/ack pulse pair to storage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module backup_ram_sequencer (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             svp_quirk,
	input  logic                             rom_loading,
	input  logic                             in_menu,
	input  logic                             bk_change,
	input  logic                             sd_ack,
	output logic                             sd_rd,
	output logic                             sd_wr,
	output logic [md_core_pkg::BK_LBA_W-1:0] sd_lba,
	output logic                             bk_busy
);

	import md_core_pkg::*;

	localparam logic [BK_LBA_W-1:0] LAST_LBA = BK_LBA_W'(BK_SECTORS - 1);

	logic bk_ena;
	logic change_q;
	logic loading_q;
	logic ack_q;
	logic pending;
	logic bk_loading;   // direction of the running transfer
	logic load_start;
	logic save_start;

	assign bk_ena     = ~svp_quirk;    // svp carts keep no backup ram
	assign load_start = bk_ena & loading_q & ~rom_loading;
	assign save_start = bk_ena & pending & in_menu;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			change_q   <= 1'b0;
			loading_q  <= 1'b0;
			ack_q      <= 1'b0;
			pending    <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			change_q  <= bk_change;
			loading_q <= rom_loading;
			ack_q     <= sd_ack;

			if (bk_change && !change_q && !in_menu)
				pending <= 1'b1;       // saved once the menu opens

			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_start || save_start) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_start;  // load wins over save
					pending    <= 1'b0;
					sd_lba     <= '0;
					sd_rd      <= load_start;
					sd_wr      <= ~load_start;
				end
			end else if (!sd_ack && ack_q) begin
				if (sd_lba == LAST_LBA) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

// File: pad_remap.sv
////////////////////////////////////////////////////////////////////////////
// controller remapper
// two flop synchronizers on the host key bitmaps, then reorder into
// console pad words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_remap (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  md_core_pkg::host_keys_t host_keys [md_core_pkg::PAD_COUNT],
	output md_core_pkg::md_pad_t    pads      [md_core_pkg::PAD_COUNT]
);

	import md_core_pkg::*;

	host_keys_t keys_meta [PAD_COUNT];
	host_keys_t keys_sync [PAD_COUNT];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			keys_meta <= '{default: '0};
			keys_sync <= '{default: '0};
		end else begin
			keys_meta <= host_keys;
			keys_sync <= keys_meta;
		end
	end

	// six button layout, select acts as mode
	always_comb begin
		for (int p = 0; p < PAD_COUNT; p++) begin
			pads[p].z     = keys_sync[p].trig_r1;
			pads[p].y     = keys_sync[p].face_x;
			pads[p].x     = keys_sync[p].trig_l1;
			pads[p].mode  = keys_sync[p].select;
			pads[p].start = keys_sync[p].start;
			pads[p].b     = keys_sync[p].face_a;
			pads[p].c     = keys_sync[p].face_b;
			pads[p].a     = keys_sync[p].face_y;
			pads[p].up    = keys_sync[p].up;
			pads[p].down  = keys_sync[p].down;
			pads[p].left  = keys_sync[p].left;
			pads[p].right = keys_sync[p].right;
		end
	end

endmodule

// File: cart_header_sniffer.sv
////////////////////////////////////////////////////////////////////////////
// cartridge header sniffer
// picks the product code out of the rom download, looks up game quirks
// and light gun timing, and records the rom size
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cart_header_sniffer (
	input  logic                               clk_sys,
	input  logic                               rst_n,
	input  logic                               rom_loading,
	input  logic                               rom_wr,
	input  logic [md_core_pkg::ROM_ADDR_W-1:0] rom_addr,
	input  logic [md_core_pkg::ROM_DATA_W-1:0] rom_data,
	output md_core_pkg::cart_quirks_t          quirks,
	output md_core_pkg::gun_cfg_t              gun,
	output logic [md_core_pkg::ROM_ADDR_W-1:0] rom_size
);

	import md_core_pkg::*;

	cart_id_t                cart_id;
	logic [ROM_ADDR_W-1:0]   last_addr;
	logic                    loading_q;
	logic                    load_write;
	logic                    hdr_done;
	quirk_e                  hit_quirk;
	gun_cfg_t                hit_gun;

	assign load_write = rom_loading & rom_wr;
	assign hdr_done   = load_write & (rom_addr == HDR_ADDR_DONE);

	// header words arrive byte swapped
	always_ff @(posedge clk_sys) begin
		if (load_write) begin
			last_addr <= rom_addr;
			case (rom_addr)
				HDR_ADDR_ID0: cart_id[7]   <= rom_data[15:8];
				HDR_ADDR_ID1: cart_id[6:5] <= {rom_data[7:0], rom_data[15:8]};
				HDR_ADDR_ID2: cart_id[4:3] <= {rom_data[7:0], rom_data[15:8]};
				HDR_ADDR_ID3: cart_id[2:1] <= {rom_data[7:0], rom_data[15:8]};
				HDR_ADDR_ID4: cart_id[0]   <= rom_data[7:0];
				default: ;
			endcase
		end
	end

	// table search, unknown codes fall back to the default gun
	always_comb begin
		hit_quirk = Q_NONE;
		hit_gun   = GUN_DEFAULT;
		for (int i = 0; i < CART_ENTRIES; i++) begin
			if (cart_id == CART_TABLE[i].code) begin
				hit_quirk = CART_TABLE[i].quirk;
				hit_gun   = CART_TABLE[i].gun;
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			loading_q <= 1'b0;
			quirks    <= '0;
			gun       <= GUN_DEFAULT;
			rom_size  <= '0;
		end else begin
			loading_q <= rom_loading;
			if (rom_loading && !loading_q)
				quirks <= '0;                  // new download starts clean
			if (!rom_loading && loading_q)
				rom_size <= last_addr;
			if (hdr_done) begin
				gun <= hit_gun;
				// Q_NONE shifts past the top bit and sets nothing
				quirks <= quirks | (QUIRK_W'(1) << hit_quirk);
			end
		end
	end

endmodule

// File: core_settings_regs.sv
////////////////////////////////////////////////////////////////////////////
// core settings registers
// video and audio option bits written by the host bridge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_settings_regs (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  logic [md_core_pkg::ADDR_W-1:0] bridge_addr,
	input  logic                           bridge_wr,
	input  logic [md_core_pkg::DATA_W-1:0] bridge_wr_data,
	output md_core_pkg::core_cfg_t         cfg
);

	import md_core_pkg::*;

	// one option per word, bit 0 only
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= CFG_DEFAULT;
		end else if (bridge_wr) begin
			case (bridge_addr)
				CFG_ADDR_BORDER:    cfg.border         <= bridge_wr_data[0];
				CFG_ADDR_CRAM_DOTS: cfg.cram_dots      <= bridge_wr_data[0];
				CFG_ADDR_SPR_LIMIT: cfg.spr_limit_high <= bridge_wr_data[0];
				CFG_ADDR_HIFI_PCM:  cfg.hifi_pcm       <= bridge_wr_data[0];
				CFG_ADDR_FM_EN:     cfg.fm_en          <= bridge_wr_data[0];
				default: ;                             // unmapped, ignored
			endcase
		end
	end

endmodule

// File: md_core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// console core glue package
// bus widths, register and header addresses, colour and cartridge tables,
// and the structs shared between the glue blocks
////////////////////////////////////////////////////////////////////////////

package md_core_pkg;

	// host bridge
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] CFG_ADDR_BORDER    = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] CFG_ADDR_CRAM_DOTS = 32'h0000_0004;
	localparam logic [ADDR_W-1:0] CFG_ADDR_SPR_LIMIT = 32'h0000_0008;
	localparam logic [ADDR_W-1:0] CFG_ADDR_HIFI_PCM  = 32'h0000_0010;
	localparam logic [ADDR_W-1:0] CFG_ADDR_FM_EN     = 32'h0000_0014;

	typedef struct packed {
		logic border;
		logic cram_dots;
		logic spr_limit_high;
		logic hifi_pcm;
		logic fm_en;
	} core_cfg_t;

	localparam core_cfg_t CFG_DEFAULT = '{border: 1'b0, cram_dots: 1'b0,
		spr_limit_high: 1'b1, hifi_pcm: 1'b1, fm_en: 1'b1};

	////////////////////////////////////////////////////////////////////////////
	// cartridge download and header
	////////////////////////////////////////////////////////////////////////////

	localparam int ROM_ADDR_W = 25;
	localparam int ROM_DATA_W = 16;

	localparam logic [ROM_ADDR_W-1:0] HDR_ADDR_ID0  = 25'h182; // high byte only
	localparam logic [ROM_ADDR_W-1:0] HDR_ADDR_ID1  = 25'h184;
	localparam logic [ROM_ADDR_W-1:0] HDR_ADDR_ID2  = 25'h186;
	localparam logic [ROM_ADDR_W-1:0] HDR_ADDR_ID3  = 25'h188;
	localparam logic [ROM_ADDR_W-1:0] HDR_ADDR_ID4  = 25'h18A; // low byte only
	localparam logic [ROM_ADDR_W-1:0] HDR_ADDR_DONE = 25'h18C;

	typedef logic [7:0][7:0] cart_id_t; // [7] is the first character

	typedef struct packed {
		logic sram;
		logic sram00;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} cart_quirks_t;

	localparam int QUIRK_W = $bits(cart_quirks_t);

	// bit position inside cart_quirks_t
	typedef enum logic [3:0] {
		Q_SCHAN  = 4'd0,
		Q_FMBUSY = 4'd1,
		Q_SVP    = 4'd2,
		Q_PIER   = 4'd3,
		Q_NORAM  = 4'd4,
		Q_FIFO   = 4'd5,
		Q_EEPROM = 4'd6,
		Q_SRAM00 = 4'd7,
		Q_SRAM   = 4'd8,
		Q_NONE   = 4'd15
	} quirk_e;

	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;
	} gun_cfg_t;

	localparam gun_cfg_t GUN_DEFAULT = '{gun_type: 1'b0, sensor_delay: 8'd44};

	typedef struct packed {
		cart_id_t code;
		quirk_e   quirk;
		gun_cfg_t gun;
	} cart_entry_t;

	localparam int CART_ENTRIES = 12;

	localparam cart_entry_t CART_TABLE [CART_ENTRIES] = '{
		'{"T-081276", Q_SRAM,   GUN_DEFAULT},      // nfl quarterback club
		'{"T-81406 ", Q_SRAM,   GUN_DEFAULT},      // nba jam te
		'{"MK-1215 ", Q_EEPROM, GUN_DEFAULT},      // real deal boxing
		'{"MK-1229 ", Q_SVP,    GUN_DEFAULT},      // virtua racing
		'{"T-89016 ", Q_FIFO,   GUN_DEFAULT},      // clue
		'{"T-113016", Q_NORAM,  GUN_DEFAULT},      // fake ram check
		'{"T-574023", Q_PIER,   GUN_DEFAULT},
		'{"T-35036 ", Q_FMBUSY, GUN_DEFAULT},
		'{"T-68???-", Q_SCHAN,  GUN_DEFAULT},
		'{" GM 0000", Q_SRAM00, GUN_DEFAULT},
		'{"T-95096-", Q_NONE,   '{1'b1, 8'd52}},   // justifier
		'{"MK-1533 ", Q_NONE,   '{1'b0, 8'd100}}   // menacer
	};

	////////////////////////////////////////////////////////////////////////////
	// controllers and backup ram
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic start;    // bit 15
		logic select;
		logic trig_r3;
		logic trig_l3;
		logic trig_r2;
		logic trig_l2;
		logic trig_r1;
		logic trig_l1;
		logic face_y;
		logic face_x;
		logic face_b;
		logic face_a;
		logic right;
		logic left;
		logic down;
		logic up;       // bit 0
	} host_keys_t;

	typedef struct packed {
		logic z;
		logic y;
		logic x;
		logic mode;
		logic start;
		logic b;
		logic c;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} md_pad_t;

	localparam int PAD_COUNT = 4;

	localparam int BK_LBA_W   = 32;
	localparam int BK_SECTORS = 128;

	////////////////////////////////////////////////////////////////////////////
	// video
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] COLOR_LUT [16] = '{
		8'd0,   8'd27,  8'd49,  8'd71,
		8'd87,  8'd103, 8'd119, 8'd130,
		8'd146, 8'd157, 8'd174, 8'd190,
		8'd206, 8'd228, 8'd255, 8'd255
	};

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888_t;

	typedef struct packed {
		logic [10:0] index;
		logic [12:0] zero;
	} vid_mode_word_t;

	// colour while active, mode index while blanked
	typedef union packed {
		rgb888_t        color;
		vid_mode_word_t mode;
	} video_word_u;

	typedef enum logic [1:0] {
		RES_256_224 = 2'd0,
		RES_320_224 = 2'd1,
		RES_256_240 = 2'd2,
		RES_320_240 = 2'd3
	} vid_mode_e;

endpackage
